// File: all.f
+incdir+common
common/gmii_tx_pkg.sv
verilog/crc32_gen.sv
verilog/pixel_packer.sv
framer/frame_header_gen.sv
framer/tx_frame_fsm.sv
verilog/gmii_udp_tx.sv
dv/gmii_udp_tx_assert.sv
dv/gmii_udp_tx_tb.sv

// File: common/gmii_tx_defines.svh
`ifndef GMII_TX_DEFINES_SVH
`define GMII_TX_DEFINES_SVH

// --------------------------------------------------
// Station addresses
// --------------------------------------------------
// Base values, the last byte is moved by station_id
`define SRC_MAC         48'h0023_4567_8901
`define DST_MAC         48'h0023_4567_8902
`define SRC_IP          32'hC0A8_0001
`define DST_IP          32'hC0A8_0002

// --------------------------------------------------
// Fixed header fields
// --------------------------------------------------
`define ETH_TYPE        16'h0800
`define IP_VER_TOS      16'h4500
`define IP_IDEN         16'h0000
`define IP_FLAG         16'h4000
`define IP_TTL          8'h40
`define IP_PROT         8'h11
`define UDP_SRC_PORT    16'h3038
`define UDP_DST_PORT    16'h3039
`define PKT_TYPE_VIDEO  8'h00

// --------------------------------------------------
// Frame geometry
// --------------------------------------------------
`define PIXEL_BYTES     1200
// IP hdr 20 + UDP hdr 8 + type 1 + resolution 2
`define IP_TOTAL_LEN    16'(31 + `PIXEL_BYTES)
`define UDP_TOTAL_LEN   16'(11 + `PIXEL_BYTES)
`define PREAMBLE_BYTES  7
`define HDR_BYTES       42
`define IFG_CYCLES      12

`endif

// File: common/gmii_tx_pkg.sv
package gmii_tx_pkg;

	// Frame phases of the transmitter
	typedef enum logic [3:0] {
		IDLE,
		PRE,
		SFD,
		HEADER,
		PKT_TYPE,
		RESOL,
		PAYLOAD,
		FCS,
		IFG
	} tx_state_e;

	// Where the next GMII byte comes from
	typedef enum logic [1:0] {
		SRC_FIXED,
		SRC_HEADER,
		SRC_PIXEL,
		SRC_CRC
	} byte_src_e;

	// Byte index inside the current field
	typedef logic [10:0] field_pos_t;

	// --------------------------------------------------
	// FIFO word, two readings of the same 48 bits
	// --------------------------------------------------
	typedef struct packed {
		logic [15:0] line_tag;
		logic [7:0]  y;
		logic [7:0]  c;
		logic [15:0] spare;
	} pix_video_t;

	typedef struct packed {
		logic [15:0] line_tag;
		logic [7:0]  red;
		logic [7:0]  green;
		logic [7:0]  blue;
		logic [7:0]  spare;
	} pix_colour_t;

	typedef union packed {
		pix_video_t  video;
		pix_colour_t colour;
	} pixel_word_u;

	// Ethernet, IPv4 and UDP headers in wire order, 42 bytes
	typedef struct packed {
		logic [47:0] dst_mac;
		logic [47:0] src_mac;
		logic [15:0] eth_type;
		logic [15:0] ver_tos;
		logic [15:0] total_len;
		logic [15:0] iden;
		logic [15:0] flag;
		logic [7:0]  ttl;
		logic [7:0]  prot;
		logic [15:0] csum;
		logic [31:0] src_ip;
		logic [31:0] dst_ip;
		logic [15:0] src_port;
		logic [15:0] dst_port;
		logic [15:0] udp_len;
		logic [15:0] udp_csum;
	} frame_hdr_t;

endpackage

// File: dv/gmii_udp_tx_assert.sv
`timescale 1ns/1ps
`include "gmii_tx_defines.svh"

module gmii_udp_tx_assert (
	input logic                   fifo_clk,
	input logic                   sys_rst,
	input logic                   fifo_empty,
	input logic                   line_ready,
	input logic                   rd_en,
	input logic                   tx_en,
	input logic [7:0]             txd,
	input gmii_tx_pkg::tx_state_e state
);

	localparam int FRAME_BYTES = `PREAMBLE_BYTES + 1 + `HDR_BYTES + 1 + 2 + `PIXEL_BYTES + 4;
	localparam int RD_PULSES   = 1 + `PIXEL_BYTES / 2;

	int unsigned fail_cnt = 0;
	logic [10:0] hi_cnt;
	logic [4:0]  lo_cnt;
	logic [9:0]  rd_cnt;

	// --------------------------------------------------
	// Run lengths of tx_en and pops per frame
	// --------------------------------------------------
	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			hi_cnt <= '0;
			lo_cnt <= 5'(`IFG_CYCLES);
			rd_cnt <= '0;
		end else begin
			hi_cnt <= tx_en ? hi_cnt + 11'd1 : '0;
			if (tx_en)
				lo_cnt <= '0;
			else if (lo_cnt != 5'd31)
				lo_cnt <= lo_cnt + 5'd1;
			if (!tx_en)
				rd_cnt <= '0;
			else if (rd_en)
				rd_cnt <= rd_cnt + 10'd1;
		end
	end

	a_frame_len: assert property (@(posedge fifo_clk) disable iff (sys_rst)
		$fell(tx_en) |-> hi_cnt == FRAME_BYTES)
		else begin
			$error("tx_en stayed high for the wrong number of cycles");
			fail_cnt++;
		end

	a_ifg: assert property (@(posedge fifo_clk) disable iff (sys_rst)
		$rose(tx_en) |-> lo_cnt >= `IFG_CYCLES)
		else begin
			$error("inter-frame gap shorter than required");
			fail_cnt++;
		end

	// Preamble then SFD
	a_preamble: assert property (@(posedge fifo_clk) disable iff (sys_rst)
		(tx_en && hi_cnt < `PREAMBLE_BYTES) |-> txd == 8'h55)
		else begin
			$error("preamble byte is not 0x55");
			fail_cnt++;
		end

	a_sfd: assert property (@(posedge fifo_clk) disable iff (sys_rst)
		(tx_en && hi_cnt == `PREAMBLE_BYTES) |-> txd == 8'hD5)
		else begin
			$error("SFD byte is not 0xD5");
			fail_cnt++;
		end

	a_rd_count: assert property (@(posedge fifo_clk) disable iff (sys_rst)
		$fell(tx_en) |-> rd_cnt == RD_PULSES)
		else begin
			$error("wrong number of FIFO pops in the frame");
			fail_cnt++;
		end

	a_rd_in_frame: assert property (@(posedge fifo_clk) disable iff (sys_rst)
		rd_en |-> tx_en)
		else begin
			$error("FIFO pop outside a frame");
			fail_cnt++;
		end

	a_start_gate: assert property (@(posedge fifo_clk) disable iff (sys_rst)
		(state == gmii_tx_pkg::IDLE && (!line_ready || fifo_empty)) |=> !tx_en)
		else begin
			$error("frame started without line_ready and a non-empty FIFO");
			fail_cnt++;
		end

endmodule

bind gmii_udp_tx gmii_udp_tx_assert u_gmii_udp_tx_assert (
	.fifo_clk  (fifo_clk),
	.sys_rst   (sys_rst),
	.fifo_empty(fifo_empty),
	.line_ready(line_ready),
	.rd_en     (rd_en),
	.tx_en     (tx_en),
	.txd       (txd),
	.state     (u_tx_frame_fsm.state)
);

// File: dv/gmii_udp_tx_tb.sv
`timescale 1ns/1ps
`include "gmii_tx_defines.svh"

module gmii_udp_tx_tb;

	localparam int FRAME_BYTES = `PREAMBLE_BYTES + 1 + `HDR_BYTES + 1 + 2 + `PIXEL_BYTES + 4;
	localparam int WORDS       = 1 + `PIXEL_BYTES / 2;
	localparam int NUM_FRAMES  = 2;
	localparam int HDR_START   = `PREAMBLE_BYTES + 1;
	localparam int RESOL_START = HDR_START + `HDR_BYTES + 1;
	localparam int PAY_START   = RESOL_START + 2;
	localparam int FCS_START   = PAY_START + `PIXEL_BYTES;
	localparam int WATCHDOG_NS = NUM_FRAMES * (FRAME_BYTES + `IFG_CYCLES + 20) * 4 + 2000;

	logic        fifo_clk = 1'b0;
	logic        sys_rst = 1'b1;
	logic [47:0] fifo_dout = '0;
	logic        fifo_empty = 1'b1;
	logic        line_ready = 1'b0;
	logic        pixel_mode = 1'b0;
	logic        station_id = 1'b0;
	logic        rd_en;
	logic        tx_en;
	logic [7:0]  txd;

	logic [47:0]              fifo_q [$];
	logic                     pop_due = 1'b0;
	gmii_tx_pkg::pixel_word_u sent_words [0:WORDS-1];
	logic [7:0]               frame_buf [0:2047];
	int                       frame_len = 0;
	int                       seed = 13958;
	int                       err_cnt = 0;
	int                       pass_cnt = 0;
	int                       fail_cnt = 0;

	gmii_udp_tx u_gmii_udp_tx (
		.fifo_clk  (fifo_clk),
		.sys_rst   (sys_rst),
		.fifo_dout (fifo_dout),
		.fifo_empty(fifo_empty),
		.line_ready(line_ready),
		.pixel_mode(pixel_mode),
		.station_id(station_id),
		.rd_en     (rd_en),
		.tx_en     (tx_en),
		.txd       (txd)
	);

	always #2 fifo_clk = ~fifo_clk;

	// FWFT FIFO model, a pop seen in one cycle takes effect after the next rising edge
	always @(negedge fifo_clk) begin
		if (pop_due && fifo_q.size() > 0)
			fifo_q.delete(0);
		pop_due    = rd_en;
		fifo_empty = (fifo_q.size() == 0);
		fifo_dout  = fifo_empty ? 48'd0 : fifo_q[0];
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before all frames finished");
		$display("TEST FAILED");
		$finish;
	end

	// --------------------------------------------------
	// Check helpers
	// --------------------------------------------------
	function automatic logic [7:0] reverse_bits8(input logic [7:0] b);
		logic [7:0] r;
		for (int i = 0; i < 8; i++)
			r[i] = b[7-i];
		return r;
	endfunction

	task automatic report_test(input string name, input int err_before);
		if (err_cnt == err_before) begin
			$display("%s: ok", name);
			pass_cnt++;
		end else begin
			$display("%s: %0d errors", name, err_cnt - err_before);
			fail_cnt++;
		end
	endtask

	task automatic check_byte(input string field, input int idx, input logic [7:0] exp);
		assert (frame_buf[idx] === exp) else begin
			$display("Mismatch %s byte %0d: txd=0x%02h expected 0x%02h",
				field, idx, frame_buf[idx], exp);
			err_cnt++;
		end
	endtask

	task automatic check_idle(input string why);
		assert (tx_en === 1'b0) else begin
			$display("tx_en went high with %s", why);
			err_cnt++;
		end
	endtask

	// One line of random FIFO words
	task automatic load_words();
		logic [31:0] rnd_hi;
		logic [31:0] rnd_lo;
		for (int i = 0; i < WORDS; i++) begin
			rnd_hi = $random(seed);
			rnd_lo = $random(seed);
			sent_words[i] = {rnd_hi[15:0], rnd_lo};
			fifo_q.push_back({rnd_hi[15:0], rnd_lo});
		end
	endtask

	task automatic capture_frame();
		frame_len = 0;
		while (tx_en === 1'b1 && frame_len < 2048) begin
			frame_buf[frame_len] = txd;
			frame_len++;
			@(negedge fifo_clk);
		end
	endtask

	// --------------------------------------------------
	// One frame, start gating first
	// --------------------------------------------------
	task automatic run_frame(input logic sid, input logic mode);
		int err_before;
		err_before = err_cnt;
		@(negedge fifo_clk);
		station_id = sid;
		pixel_mode = mode;
		line_ready = 1'b1;
		repeat (16) begin
			@(negedge fifo_clk);
			check_idle("an empty FIFO");
		end
		line_ready = 1'b0;
		@(posedge fifo_clk);
		load_words();
		repeat (16) begin
			@(negedge fifo_clk);
			check_idle("line_ready low");
		end
		line_ready = 1'b1;
		@(negedge fifo_clk);
		assert (tx_en === 1'b1) else begin
			$display("tx_en did not rise one cycle after the start condition");
			err_cnt++;
		end
		report_test($sformatf("start gating sid=%0d mode=%0d", sid, mode), err_before);
		capture_frame();
		line_ready = 1'b0;
	endtask

	// Next line queued during the gap, so the frame follows at the minimum spacing
	task automatic run_next_frame(input logic sid, input logic mode);
		int err_before;
		int low_cycles;
		err_before = err_cnt;
		station_id = sid;
		pixel_mode = mode;
		line_ready = 1'b1;
		@(posedge fifo_clk);
		load_words();
		@(negedge fifo_clk);
		low_cycles = 0;
		while (tx_en !== 1'b1 && low_cycles < `IFG_CYCLES + 8) begin
			@(negedge fifo_clk);
			low_cycles++;
		end
		assert (tx_en === 1'b1) else begin
			$display("tx_en did not rise after the inter-frame gap");
			err_cnt++;
		end
		report_test($sformatf("back-to-back start sid=%0d mode=%0d", sid, mode), err_before);
		capture_frame();
		line_ready = 1'b0;
	endtask

	task automatic check_header(input logic sid);
		int           err_before;
		logic [47:0]  dmac;
		logic [47:0]  smac;
		logic [31:0]  sip;
		logic [31:0]  dip;
		logic [31:0]  sum;
		logic [15:0]  csum;
		logic [335:0] hdr;
		err_before = err_cnt;
		dmac = `DST_MAC;
		smac = `SRC_MAC;
		sip  = `SRC_IP;
		dip  = `DST_IP;
		dmac[7:0] = dmac[7:0] - {7'd0, sid};
		smac[7:0] = smac[7:0] + {7'd0, sid};
		sip[7:0]  = sip[7:0] + {7'd0, sid};
		dip[7:0]  = dip[7:0] - {7'd0, sid};
		// One's-complement sum, checksum word taken as zero
		sum = 32'd0 + `IP_VER_TOS + `IP_TOTAL_LEN + `IP_IDEN + `IP_FLAG
			+ {`IP_TTL, `IP_PROT} + sip[31:16] + sip[15:0] + dip[31:16] + dip[15:0];
		while (sum[31:16] != 16'd0)
			sum = {16'd0, sum[15:0]} + {16'd0, sum[31:16]};
		csum = ~sum[15:0];
		hdr = {dmac, smac, `ETH_TYPE, `IP_VER_TOS, `IP_TOTAL_LEN, `IP_IDEN, `IP_FLAG,
			`IP_TTL, `IP_PROT, csum, sip, dip, `UDP_SRC_PORT, `UDP_DST_PORT,
			`UDP_TOTAL_LEN, 16'h0000};
		for (int i = 0; i < `HDR_BYTES; i++)
			check_byte("header", HDR_START + i, hdr[335 - 8*i -: 8]);
		report_test($sformatf("header sid=%0d", sid), err_before);
	endtask

	task automatic check_payload(input logic mode);
		int                       err_before;
		gmii_tx_pkg::pixel_word_u w;
		logic [7:0]               first_b;
		logic [7:0]               second_b;
		err_before = err_cnt;
		check_byte("packet type", RESOL_START - 1, `PKT_TYPE_VIDEO);
		check_byte("resolution", RESOL_START, sent_words[0].video.line_tag[15:8]);
		check_byte("resolution", RESOL_START + 1, sent_words[0].video.line_tag[7:0]);
		// First word only carries the line tag
		for (int k = 0; k < `PIXEL_BYTES / 2; k++) begin
			w = sent_words[k + 1];
			first_b  = mode ? w.colour.green : w.video.y;
			second_b = mode ? w.colour.red : w.video.c;
			check_byte("payload", PAY_START + 2*k, first_b);
			check_byte("payload", PAY_START + 2*k + 1, second_b);
		end
		report_test($sformatf("payload mode=%0d", mode), err_before);
	endtask

	task automatic check_fcs(input string name);
		int          err_before;
		logic [31:0] crc;
		logic        bit_in;
		err_before = err_cnt;
		assert (frame_len == FRAME_BYTES) else begin
			$display("Frame held tx_en for %0d bytes instead of %0d", frame_len, FRAME_BYTES);
			err_cnt++;
		end
		// MSB-first CRC-32, each byte enters LSB first as on the wire
		crc = 32'hFFFF_FFFF;
		for (int i = HDR_START; i < FCS_START; i++) begin
			for (int b = 0; b < 8; b++) begin
				bit_in = frame_buf[i][b] ^ crc[31];
				crc = {crc[30:0], 1'b0} ^ (bit_in ? 32'h04C1_1DB7 : 32'h0);
			end
		end
		crc = ~crc;
		for (int k = 0; k < 4; k++)
			check_byte("fcs", FCS_START + k, reverse_bits8(crc[31 - 8*k -: 8]));
		report_test(name, err_before);
	endtask

	// --------------------------------------------------
	// Test sequence
	// --------------------------------------------------
	initial begin
		repeat (3) @(negedge fifo_clk);
		sys_rst = 1'b0;
		repeat (4) @(negedge fifo_clk);
		run_frame(1'b0, 1'b0);
		check_header(1'b0);
		check_payload(1'b0);
		check_fcs("fcs frame 0");
		run_next_frame(1'b1, 1'b1);
		check_header(1'b1);
		check_payload(1'b1);
		check_fcs("fcs frame 1");
		repeat (4) @(negedge fifo_clk);
		if (u_gmii_udp_tx.u_gmii_udp_tx_assert.fail_cnt != 0) begin
			$display("bound assertions: %0d failures",
				u_gmii_udp_tx.u_gmii_udp_tx_assert.fail_cnt);
			fail_cnt++;
		end else begin
			$display("bound assertions: ok");
			pass_cnt++;
		end
		$display("summary: %0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: framer/frame_header_gen.sv
`timescale 1ns/1ps
`include "gmii_tx_defines.svh"

module frame_header_gen (
	input  logic                    fifo_clk,
	input  logic                    sys_rst,
	input  logic                    station_id,
	input  logic                    header_go,
	input  gmii_tx_pkg::field_pos_t field_pos,
	output logic [7:0]              header_byte
);

	localparam logic [47:0] SRC_MAC_BASE = `SRC_MAC;
	localparam logic [47:0] DST_MAC_BASE = `DST_MAC;
	localparam logic [31:0] SRC_IP_BASE  = `SRC_IP;
	localparam logic [31:0] DST_IP_BASE  = `DST_IP;

	gmii_tx_pkg::frame_hdr_t     hdr;
	logic [`HDR_BYTES*8-1:0]     hdr_bits;
	logic [15:0]                 ip_word [0:9];
	logic [2:0]                  sum_step;
	logic [3:0]                  pair_lo;
	logic [3:0]                  pair_hi;
	logic [19:0]                 sum_acc;
	logic [15:0]                 ip_csum;
	logic [5:0]                  byte_idx;

	// --------------------------------------------------
	// Header image
	// --------------------------------------------------
	always_comb begin
		hdr.dst_mac   = {DST_MAC_BASE[47:8], DST_MAC_BASE[7:0] - {7'd0, station_id}};
		hdr.src_mac   = {SRC_MAC_BASE[47:8], SRC_MAC_BASE[7:0] + {7'd0, station_id}};
		hdr.eth_type  = `ETH_TYPE;
		hdr.ver_tos   = `IP_VER_TOS;
		hdr.total_len = `IP_TOTAL_LEN;
		hdr.iden      = `IP_IDEN;
		hdr.flag      = `IP_FLAG;
		hdr.ttl       = `IP_TTL;
		hdr.prot      = `IP_PROT;
		hdr.csum      = ip_csum;
		hdr.src_ip    = {SRC_IP_BASE[31:8], SRC_IP_BASE[7:0] + {7'd0, station_id}};
		hdr.dst_ip    = {DST_IP_BASE[31:8], DST_IP_BASE[7:0] - {7'd0, station_id}};
		hdr.src_port  = `UDP_SRC_PORT;
		hdr.dst_port  = `UDP_DST_PORT;
		hdr.udp_len   = `UDP_TOTAL_LEN;
		// UDP checksum not used
		hdr.udp_csum  = 16'h0000;
	end

	// Ten IPv4 header words, checksum slot counted as zero
	always_comb begin
		ip_word[0] = hdr.ver_tos;
		ip_word[1] = hdr.total_len;
		ip_word[2] = hdr.iden;
		ip_word[3] = hdr.flag;
		ip_word[4] = {hdr.ttl, hdr.prot};
		ip_word[5] = 16'h0000;
		ip_word[6] = hdr.src_ip[31:16];
		ip_word[7] = hdr.src_ip[15:0];
		ip_word[8] = hdr.dst_ip[31:16];
		ip_word[9] = hdr.dst_ip[15:0];
	end

	// --------------------------------------------------
	// Checksum, two words per step, fold on step 6
	// --------------------------------------------------
	assign pair_lo = {sum_step - 3'd1, 1'b0};
	assign pair_hi = {sum_step - 3'd1, 1'b1};

	always_ff @(posedge fifo_clk) begin
		if (sys_rst)
			sum_step <= '0;
		else if (header_go)
			sum_step <= 3'd1;
		else if (sum_step == 3'd6)
			sum_step <= '0;
		else if (sum_step != '0)
			sum_step <= sum_step + 3'd1;
	end

	always_ff @(posedge fifo_clk) begin
		if (header_go)
			sum_acc <= '0;
		else if (sum_step == 3'd6)
			sum_acc <= {4'd0, sum_acc[15:0]} + {16'd0, sum_acc[19:16]};
		else if (sum_step != '0)
			sum_acc <= sum_acc + {4'd0, ip_word[pair_lo]} + {4'd0, ip_word[pair_hi]};
	end

	// Last end-around carry folded here
	assign ip_csum = ~(sum_acc[15:0] + {15'd0, sum_acc[16]});

	// Byte 0 sits in the top bits of the image
	assign hdr_bits    = hdr;
	assign byte_idx    = 6'(`HDR_BYTES - 1) - field_pos[5:0];
	assign header_byte = (field_pos < `HDR_BYTES) ? hdr_bits[{byte_idx, 3'b000} +: 8] : 8'h00;

endmodule

// File: framer/tx_frame_fsm.sv
`timescale 1ns/1ps
`include "gmii_tx_defines.svh"

module tx_frame_fsm (
	input  logic                    fifo_clk,
	input  logic                    sys_rst,
	input  logic                    fifo_empty,
	input  logic                    line_ready,
	input  logic [7:0]              header_byte,
	input  logic [7:0]              pix_byte,
	input  logic [31:0]             crc_out,
	output logic                    header_go,
	output logic                    resol_go,
	output logic                    payload_go,
	output logic                    crc_init,
	output gmii_tx_pkg::field_pos_t field_pos,
	output logic                    tx_en,
	output logic [7:0]              txd
);

	gmii_tx_pkg::tx_state_e state;
	gmii_tx_pkg::byte_src_e byte_src;
	logic [3:0]             gap_cnt;
	logic [23:0]            fcs_hold;
	logic                   start;
	logic                   frame_live;
	logic [7:0]             fixed_byte;
	logic [7:0]             next_byte;

	// Preamble byte 0 is issued from IDLE so tx_en rises one cycle after start
	assign start      = (state == gmii_tx_pkg::IDLE) && !fifo_empty && line_ready;
	assign header_go  = start;
	assign resol_go   = (state == gmii_tx_pkg::RESOL);
	assign payload_go = (state == gmii_tx_pkg::PAYLOAD);
	assign frame_live = start || !(state inside {gmii_tx_pkg::IDLE, gmii_tx_pkg::IFG});

	// --------------------------------------------------
	// Byte source selection
	// --------------------------------------------------
	always_comb begin
		byte_src   = gmii_tx_pkg::SRC_FIXED;
		fixed_byte = 8'h55;
		case (state)
			gmii_tx_pkg::SFD:      fixed_byte = 8'hD5;
			gmii_tx_pkg::HEADER:   byte_src = gmii_tx_pkg::SRC_HEADER;
			gmii_tx_pkg::PKT_TYPE: fixed_byte = `PKT_TYPE_VIDEO;
			gmii_tx_pkg::RESOL:    byte_src = gmii_tx_pkg::SRC_PIXEL;
			gmii_tx_pkg::PAYLOAD:  byte_src = gmii_tx_pkg::SRC_PIXEL;
			gmii_tx_pkg::FCS:      byte_src = gmii_tx_pkg::SRC_CRC;
			default:               fixed_byte = 8'h55;
		endcase
	end

	// FCS byte 0 straight from the CRC, the rest from the held copy
	always_comb begin
		case (byte_src)
			gmii_tx_pkg::SRC_HEADER: next_byte = header_byte;
			gmii_tx_pkg::SRC_PIXEL:  next_byte = pix_byte;
			gmii_tx_pkg::SRC_CRC:    next_byte = (field_pos == '0) ? crc_out[31:24] : fcs_hold[23:16];
			default:                 next_byte = fixed_byte;
		endcase
	end

	always_ff @(posedge fifo_clk) begin
		if (state == gmii_tx_pkg::FCS) begin
			fcs_hold <= (field_pos == '0) ? crc_out[23:0] : {fcs_hold[15:0], 8'h00};
		end
	end

	// --------------------------------------------------
	// Phase sequencing
	// --------------------------------------------------
	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			state     <= gmii_tx_pkg::IDLE;
			field_pos <= '0;
			gap_cnt   <= '0;
			crc_init  <= 1'b0;
			tx_en     <= 1'b0;
			txd       <= 8'h00;
		end else begin
			tx_en     <= frame_live;
			txd       <= frame_live ? next_byte : 8'h00;
			crc_init  <= (state == gmii_tx_pkg::SFD);
			field_pos <= field_pos + 11'd1;
			case (state)
				gmii_tx_pkg::IDLE: begin
					field_pos <= 11'd1;
					if (start)
						state <= gmii_tx_pkg::PRE;
				end
				gmii_tx_pkg::PRE: begin
					if (field_pos == 11'(`PREAMBLE_BYTES - 1)) begin
						state     <= gmii_tx_pkg::SFD;
						field_pos <= '0;
					end
				end
				gmii_tx_pkg::SFD: begin
					state     <= gmii_tx_pkg::HEADER;
					field_pos <= '0;
				end
				gmii_tx_pkg::HEADER: begin
					if (field_pos == 11'(`HDR_BYTES - 1)) begin
						state     <= gmii_tx_pkg::PKT_TYPE;
						field_pos <= '0;
					end
				end
				gmii_tx_pkg::PKT_TYPE: begin
					state     <= gmii_tx_pkg::RESOL;
					field_pos <= '0;
				end
				gmii_tx_pkg::RESOL: begin
					if (field_pos == 11'd1) begin
						state     <= gmii_tx_pkg::PAYLOAD;
						field_pos <= '0;
					end
				end
				gmii_tx_pkg::PAYLOAD: begin
					if (field_pos == 11'(`PIXEL_BYTES - 1)) begin
						state     <= gmii_tx_pkg::FCS;
						field_pos <= '0;
					end
				end
				gmii_tx_pkg::FCS: begin
					if (field_pos == 11'd3) begin
						state     <= gmii_tx_pkg::IFG;
						field_pos <= '0;
						// One idle cycle is spent leaving FCS
						gap_cnt   <= 4'(`IFG_CYCLES - 1);
					end
				end
				default: begin
					field_pos <= '0;
					if (gap_cnt == '0)
						state <= gmii_tx_pkg::IDLE;
					else
						gap_cnt <= gap_cnt - 4'd1;
				end
			endcase
		end
	end

endmodule

// File: verilog/crc32_gen.sv
`timescale 1ns/1ps

module crc32_gen (
	input  logic        fifo_clk,
	input  logic        sys_rst,
	input  logic        crc_init,
	input  logic        tx_en,
	input  logic [7:0]  txd,
	output logic [31:0] crc_out
);

	logic [31:0] crc_q;
	logic [31:0] crc_next;
	logic [31:0] fcs;

	// Reflected form of polynomial 0x04C11DB7, LSB first
	function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] data);
		logic [31:0] c;
		c = crc ^ {24'd0, data};
		for (int i = 0; i < 8; i++) begin
			c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
		end
		return c;
	endfunction

	// Includes the byte on txd now, so the FCS is ready as the last payload byte leaves
	assign crc_next = tx_en ? crc_byte(crc_q, txd) : crc_q;
	assign fcs      = ~crc_next;

	// Wire order is fcs[7:0] first, placed in the top byte for the sequencer
	assign crc_out = {fcs[7:0], fcs[15:8], fcs[23:16], fcs[31:24]};

	always_ff @(posedge fifo_clk) begin
		if (sys_rst)
			crc_q <= '1;
		else if (crc_init)
			crc_q <= '1;
		else
			crc_q <= crc_next;
	end

endmodule

// File: verilog/gmii_udp_tx.sv
`timescale 1ns/1ps

module gmii_udp_tx (
	input  logic        fifo_clk,
	input  logic        sys_rst,
	input  logic [47:0] fifo_dout,
	input  logic        fifo_empty,
	input  logic        line_ready,
	input  logic        pixel_mode,
	input  logic        station_id,
	output logic        rd_en,
	output logic        tx_en,
	output logic [7:0]  txd
);

	logic                    header_go;
	logic                    resol_go;
	logic                    payload_go;
	logic                    crc_init;
	gmii_tx_pkg::field_pos_t field_pos;
	logic [7:0]              header_byte;
	logic [7:0]              pix_byte;
	logic [31:0]             crc_out;

	// Sequencer owns the txd register and its source mux
	tx_frame_fsm u_tx_frame_fsm (
		.fifo_clk   (fifo_clk),
		.sys_rst    (sys_rst),
		.fifo_empty (fifo_empty),
		.line_ready (line_ready),
		.header_byte(header_byte),
		.pix_byte   (pix_byte),
		.crc_out    (crc_out),
		.header_go  (header_go),
		.resol_go   (resol_go),
		.payload_go (payload_go),
		.crc_init   (crc_init),
		.field_pos  (field_pos),
		.tx_en      (tx_en),
		.txd        (txd)
	);

	frame_header_gen u_frame_header_gen (
		.fifo_clk   (fifo_clk),
		.sys_rst    (sys_rst),
		.station_id (station_id),
		.header_go  (header_go),
		.field_pos  (field_pos),
		.header_byte(header_byte)
	);

	pixel_packer u_pixel_packer (
		.fifo_clk  (fifo_clk),
		.sys_rst   (sys_rst),
		.fifo_dout (fifo_dout),
		.pixel_mode(pixel_mode),
		.resol_go  (resol_go),
		.payload_go(payload_go),
		.field_pos (field_pos),
		.pix_byte  (pix_byte),
		.rd_en     (rd_en)
	);

	// CRC runs on the registered GMII byte stream
	crc32_gen u_crc32_gen (
		.fifo_clk(fifo_clk),
		.sys_rst (sys_rst),
		.crc_init(crc_init),
		.tx_en   (tx_en),
		.txd     (txd),
		.crc_out (crc_out)
	);

endmodule

// File: verilog/pixel_packer.sv
`timescale 1ns/1ps

module pixel_packer (
	input  logic                     fifo_clk,
	input  logic                     sys_rst,
	input  gmii_tx_pkg::pixel_word_u fifo_dout,
	input  logic                     pixel_mode,
	input  logic                     resol_go,
	input  logic                     payload_go,
	input  gmii_tx_pkg::field_pos_t  field_pos,
	output logic [7:0]               pix_byte,
	output logic                     rd_en
);

	// Second byte of the current payload pair
	logic pair_sel;

	always_ff @(posedge fifo_clk) begin
		if (sys_rst)
			pair_sel <= 1'b0;
		else if (!payload_go)
			pair_sel <= 1'b0;
		else
			pair_sel <= ~pair_sel;
	end

	// --------------------------------------------------
	// Byte selection
	// --------------------------------------------------
	always_comb begin
		if (resol_go) begin
			// Line tag, high byte first
			if (field_pos == '0)
				pix_byte = fifo_dout.video.line_tag[15:8];
			else
				pix_byte = fifo_dout.video.line_tag[7:0];
		end else if (pixel_mode) begin
			pix_byte = pair_sel ? fifo_dout.colour.red : fifo_dout.colour.green;
		end else begin
			pix_byte = pair_sel ? fifo_dout.video.c : fifo_dout.video.y;
		end
	end

	// FWFT pop once the word's last byte is taken
	assign rd_en = (resol_go && field_pos == 11'd1) || (payload_go && pair_sel);

endmodule
